//--- source/snes_bus_pkg.sv
package snes_bus_pkg;

  //////////////////////////////
  // Console bus side
  //////////////////////////////

  // Full 24-bit console address, bank in the top byte
  typedef logic [23:0] snes_addr_t;

  // One sampled bus cycle
  typedef struct packed {
    snes_addr_t addr;
    logic [7:0] pa;
    logic       romsel;
  } snes_req_t;

  //////////////////////////////
  // Decoded result
  //////////////////////////////

  // What the memory side gets for one access
  typedef struct packed {
    logic [23:0] rom_addr;
    logic        rom_hit;
    logic        is_rom;
    logic        is_saveram;
    logic        is_writable;
    logic [7:0]  enables;
  } map_res_t;

  // Bit positions in the enable vector
  localparam int EN_MSU     = 0;
  localparam int EN_213F    = 1;
  localparam int EN_SNESCMD = 2;
  localparam int EN_NMICMD  = 3;
  localparam int EN_RETVEC  = 4;
  localparam int EN_BRANCH1 = 5;
  localparam int EN_BRANCH2 = 6;
  // GSU register window
  localparam int EN_GSU     = 7;

endpackage

//--- source/cart_cfg_pkg.sv
package cart_cfg_pkg;

  //////////////////////////////
  // Feature bits
  //////////////////////////////

  // Positions in the 8-bit featurebits word
  localparam int FEAT_MSU1 = 3;
  localparam int FEAT_213F = 4;
  localparam int FEAT_GSU  = 5;

  //////////////////////////////
  // Masks and fixed addresses
  //////////////////////////////

  // Save-RAM and ROM masks cover the whole memory address
  localparam int MASK_W = 24;
  typedef logic [MASK_W-1:0] cart_mask_t;

  // Save RAM lives at the top of the memory
  localparam logic [23:0] SAVERAM_BASE = 24'hE00000;

  // Firmware hook locations in bank 00
  localparam logic [23:0] NMICMD_ADDR  = 24'h002BF2;
  localparam logic [23:0] RETVEC_ADDR  = 24'h002A5A;
  localparam logic [23:0] BRANCH1_ADDR = 24'h002A13;
  localparam logic [23:0] BRANCH2_ADDR = 24'h002A4D;

endpackage

//--- source/snes_req_capture.sv
`timescale 1ns/1ps

module snes_req_capture (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  logic                     cyc_start,
  input  snes_bus_pkg::snes_addr_t bus_addr,
  input  logic [7:0]               bus_pa,
  input  logic                     bus_romsel,
  input  logic                     push_ack,
  output logic                     busy,
  output logic                     push_req,
  output snes_bus_pkg::snes_req_t  push_data,
  output logic [7:0]               overrun_count
);

  // Sender side of the push handshake
  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_RELEASE
  } cap_state_t;

  cap_state_t state;
  logic       take;

  // Strobe only lands when the hold register is free
  assign take     = cyc_start && (state == S_IDLE);
  assign busy     = (state != S_IDLE);
  assign push_req = (state == S_REQ);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          if (cyc_start) begin
            state <= S_REQ;
          end
        end
        // Hold req until the FIFO has the data
        S_REQ: begin
          if (push_ack) begin
            state <= S_RELEASE;
          end
        end
        // Wait for ack low before the next cycle
        default: begin
          if (!push_ack) begin
            state <= S_IDLE;
          end
        end
      endcase
    end
  end

  // Hold register
  always_ff @(posedge CLK) begin
    if (take) begin
      push_data.addr   <= bus_addr;
      push_data.pa     <= bus_pa;
      push_data.romsel <= bus_romsel;
    end
  end

  // Dropped strobes, saturating
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      overrun_count <= '0;
    end else if (cyc_start && busy && (overrun_count != 8'hFF)) begin
      overrun_count <= overrun_count + 8'd1;
    end
  end

endmodule

//--- source/req_fifo.sv
`timescale 1ns/1ps

module req_fifo #(
  parameter type PAYLOAD_T = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     CLK,
  input  logic     rst_n,
  input  logic     push_req,
  input  PAYLOAD_T push_data,
  input  logic     pop_ack,
  output logic     push_ack,
  output logic     pop_req,
  output PAYLOAD_T pop_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  PAYLOAD_T         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             do_write;
  logic             do_read;

  // Pointer step with wrap at DEPTH
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full = (count == CNT_W'(DEPTH));

  // Write on the rising edge of our ack, read on the rising edge of theirs
  assign do_write = push_req && !push_ack && !full;
  assign do_read  = pop_req && pop_ack;

  // Head entry stays put while req is up
  assign pop_data = mem[rd_ptr];

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      push_ack <= 1'b0;
      pop_req  <= 1'b0;
    end else begin
      // Input side, receiver
      if (do_write) begin
        wr_ptr   <= next_ptr(wr_ptr);
        push_ack <= 1'b1;
      end else if (push_ack && !push_req) begin
        push_ack <= 1'b0;
      end
      // Output side, sender
      if (do_read) begin
        rd_ptr  <= next_ptr(rd_ptr);
        pop_req <= 1'b0;
      end else if (!pop_req && !pop_ack && (count != '0)) begin
        pop_req <= 1'b1;
      end
      // Occupancy
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge CLK) begin
    if (do_write) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

//--- source/address_decode.sv
`timescale 1ns/1ps

module address_decode (
  input  logic [7:0]               featurebits,
  input  snes_bus_pkg::snes_addr_t snes_addr,
  input  logic [7:0]               snes_pa,
  input  logic                     snes_romsel,
  input  cart_cfg_pkg::cart_mask_t saveram_mask,
  input  cart_cfg_pkg::cart_mask_t rom_mask,
  output logic [23:0]              rom_addr,
  output logic                     rom_hit,
  output logic                     is_rom,
  output logic                     is_saveram,
  output logic                     is_writable,
  output logic [7:0]               enables
);

  import snes_bus_pkg::*;
  import cart_cfg_pkg::*;

  logic [23:0] sram_offset;
  logic [23:0] rom_offset;

  //////////////////////////////
  // Memory regions
  //////////////////////////////

  // Upper half, or 8000-FFFF of lower banks
  assign is_rom = snes_addr[22] | snes_addr[15];

  // 60-7F/E0-FF whole bank, or 6000-7FFF of lower banks
  assign is_saveram = saveram_mask[0]
                    & ~snes_romsel
                    & ((&snes_addr[22:21])
                      | (~snes_addr[22] & (&snes_addr[14:13])));

  // Save RAM is the only writable area
  assign is_writable = is_saveram;
  assign rom_hit     = is_rom | is_writable;

  //////////////////////////////
  // Address translation
  //////////////////////////////

  // Save RAM offset, bank bits joined to the 8K window in lower banks
  assign sram_offset = snes_addr[22]
                     ? {3'b000, snes_addr[20:0]}
                     : {5'b00000, snes_addr[21:16], snes_addr[12:0]};

  // Hybrid GSU layout: HiROM style up top, LoROM style below
  assign rom_offset = snes_addr[22]
                    ? {2'b00, snes_addr[21:0]}
                    : {2'b00, snes_addr[22:16], snes_addr[14:0]};

  assign rom_addr = is_saveram
                  ? SAVERAM_BASE + (sram_offset & saveram_mask)
                  : rom_offset & rom_mask;

  //////////////////////////////
  // Peripheral enables
  //////////////////////////////

  // MSU at 2000-2007 in lower banks
  assign enables[EN_MSU] = featurebits[FEAT_MSU1]
                         & ~snes_addr[22]
                         & ((snes_addr[15:0] & 16'hFFF8) == 16'h2000);
  // PPU status read on B bus
  assign enables[EN_213F] = featurebits[FEAT_213F] & (snes_pa == 8'h3F);
  // 2A00-2BFF in lower banks
  assign enables[EN_SNESCMD] = ({snes_addr[22], snes_addr[15:9]} == 8'b0_0010101);
  // Exact hook matches
  assign enables[EN_NMICMD]  = (snes_addr == NMICMD_ADDR);
  assign enables[EN_RETVEC]  = (snes_addr == RETVEC_ADDR);
  assign enables[EN_BRANCH1] = (snes_addr == BRANCH1_ADDR);
  assign enables[EN_BRANCH2] = (snes_addr == BRANCH2_ADDR);
  // GSU regs 3000-32FF, 3300-33FF left out
  assign enables[EN_GSU] = featurebits[FEAT_GSU]
                         & ~snes_addr[22]
                         & (snes_addr[15:10] == 6'b001100)
                         & (snes_addr[9:8] != 2'b11);

endmodule

//--- source/map_stage.sv
`timescale 1ns/1ps

module map_stage (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  logic [7:0]               featurebits,
  input  cart_cfg_pkg::cart_mask_t saveram_mask,
  input  cart_cfg_pkg::cart_mask_t rom_mask,
  input  logic                     pop_req,
  input  snes_bus_pkg::snes_req_t  pop_data,
  input  logic                     push_ack,
  output logic                     pop_ack,
  output logic                     push_req,
  output snes_bus_pkg::map_res_t   push_data
);

  import snes_bus_pkg::*;

  // Offer, then wait for ack to fall
  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_RELEASE
  } map_state_t;

  map_state_t  state;
  logic        take;
  map_res_t    dec;
  logic [23:0] dec_rom_addr;
  logic        dec_rom_hit;
  logic        dec_is_rom;
  logic        dec_is_saveram;
  logic        dec_is_writable;
  logic [7:0]  dec_enables;

  address_decode i_decode (
    .featurebits  (featurebits),
    .snes_addr    (pop_data.addr),
    .snes_pa      (pop_data.pa),
    .snes_romsel  (pop_data.romsel),
    .saveram_mask (saveram_mask),
    .rom_mask     (rom_mask),
    .rom_addr     (dec_rom_addr),
    .rom_hit      (dec_rom_hit),
    .is_rom       (dec_is_rom),
    .is_saveram   (dec_is_saveram),
    .is_writable  (dec_is_writable),
    .enables      (dec_enables)
  );

  assign dec = '{dec_rom_addr, dec_rom_hit, dec_is_rom, dec_is_saveram,
                 dec_is_writable, dec_enables};

  // New request only once both handshakes are back to rest
  assign take     = (state == S_IDLE) && pop_req && !pop_ack;
  assign push_req = (state == S_REQ);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state   <= S_IDLE;
      pop_ack <= 1'b0;
    end else begin
      // Receiver side toward the request FIFO
      if (take) begin
        pop_ack <= 1'b1;
      end else if (pop_ack && !pop_req) begin
        pop_ack <= 1'b0;
      end
      case (state)
        S_IDLE:    state <= take ? S_REQ : S_IDLE;
        S_REQ:     state <= push_ack ? S_RELEASE : S_REQ;
        default:   state <= push_ack ? S_RELEASE : S_IDLE;
      endcase
    end
  end

  // Result register, loaded in the ack cycle
  always_ff @(posedge CLK) begin
    if (take) begin
      push_data <= dec;
    end
  end

endmodule

//--- source/cart_map_top.sv
`timescale 1ns/1ps

module cart_map_top #(
  parameter int REQ_DEPTH = 4,
  parameter int RES_DEPTH = 4
) (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  logic [7:0]               featurebits,
  input  cart_cfg_pkg::cart_mask_t saveram_mask,
  input  cart_cfg_pkg::cart_mask_t rom_mask,
  input  logic                     cyc_start,
  input  snes_bus_pkg::snes_addr_t bus_addr,
  input  logic [7:0]               bus_pa,
  input  logic                     bus_romsel,
  input  logic                     mem_ack,
  output logic                     busy,
  output logic [7:0]               overrun_count,
  output logic                     mem_req,
  output logic [23:0]              mem_rom_addr,
  output logic                     mem_rom_hit,
  output logic                     mem_is_rom,
  output logic                     mem_is_saveram,
  output logic                     mem_is_writable,
  output logic [7:0]               mem_enables
);

  import snes_bus_pkg::*;

  // Capture to request FIFO
  logic      cap_req;
  logic      cap_ack;
  snes_req_t cap_data;
  // Request FIFO to mapper
  logic      rq_req;
  logic      rq_ack;
  snes_req_t rq_data;
  // Mapper to result FIFO
  logic      ms_req;
  logic      ms_ack;
  map_res_t  ms_data;
  // Result FIFO head
  map_res_t  mem_data;

  snes_req_capture i_capture (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .cyc_start     (cyc_start),
    .bus_addr      (bus_addr),
    .bus_pa        (bus_pa),
    .bus_romsel    (bus_romsel),
    .push_ack      (cap_ack),
    .busy          (busy),
    .push_req      (cap_req),
    .push_data     (cap_data),
    .overrun_count (overrun_count)
  );

  req_fifo #(
    .PAYLOAD_T (snes_req_t),
    .DEPTH     (REQ_DEPTH)
  ) i_req_fifo (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .push_req  (cap_req),
    .push_data (cap_data),
    .pop_ack   (rq_ack),
    .push_ack  (cap_ack),
    .pop_req   (rq_req),
    .pop_data  (rq_data)
  );

  map_stage i_map (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .featurebits  (featurebits),
    .saveram_mask (saveram_mask),
    .rom_mask     (rom_mask),
    .pop_req      (rq_req),
    .pop_data     (rq_data),
    .push_ack     (ms_ack),
    .pop_ack      (rq_ack),
    .push_req     (ms_req),
    .push_data    (ms_data)
  );

  req_fifo #(
    .PAYLOAD_T (map_res_t),
    .DEPTH     (RES_DEPTH)
  ) i_res_fifo (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .push_req  (ms_req),
    .push_data (ms_data),
    .pop_ack   (mem_ack),
    .push_ack  (ms_ack),
    .pop_req   (mem_req),
    .pop_data  (mem_data)
  );

  // Result fields out as plain ports
  assign mem_rom_addr    = mem_data.rom_addr;
  assign mem_rom_hit     = mem_data.rom_hit;
  assign mem_is_rom      = mem_data.is_rom;
  assign mem_is_saveram  = mem_data.is_saveram;
  assign mem_is_writable = mem_data.is_writable;
  assign mem_enables     = mem_data.enables;

endmodule

//--- sim/tb_cart_model.sv
package tb_cart_model;

  import snes_bus_pkg::*;
  import cart_cfg_pkg::*;

  // One 32-bit xorshift step
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  //////////////////////////////
  // Reference memory map
  //////////////////////////////

  function automatic map_res_t model_map(input logic [7:0] feat,
                                         input cart_mask_t sram_mask,
                                         input cart_mask_t rmask,
                                         input snes_req_t  req);
    map_res_t    res;
    logic [7:0]  bank;
    logic [15:0] off;
    logic        low_bank;
    logic [23:0] sram_off;
    logic [23:0] rom_off;
    bank     = req.addr[23:16];
    off      = req.addr[15:0];
    // Banks 00-3F and 80-BF
    low_bank = (bank[6] == 1'b0);
    res      = '0;
    // ROM, whole upper banks or from 8000 in lower banks
    res.is_rom = !low_bank || (off >= 16'h8000);
    // Save RAM needs mask bit 0 and ROMSEL low
    if (sram_mask[0] && !req.romsel) begin
      if (!low_bank) begin
        // Banks 60-7F and E0-FF
        res.is_saveram = (bank[5] == 1'b1);
      end else begin
        // 6000-7FFF, A15 not looked at
        res.is_saveram = (off[14:0] >= 15'h6000);
      end
    end
    res.is_writable = res.is_saveram;
    res.rom_hit     = res.is_rom || res.is_saveram;
    // 32K ROM pages and 8K save pages in lower banks
    if (low_bank) begin
      rom_off  = (24'(bank[5:0]) << 15) + 24'(off[14:0]);
      sram_off = (24'(bank[5:0]) << 13) + 24'(off[12:0]);
    end else begin
      rom_off  = req.addr & 24'h3FFFFF;
      sram_off = req.addr & 24'h1FFFFF;
    end
    if (res.is_saveram) begin
      res.rom_addr = SAVERAM_BASE + (sram_off & sram_mask);
    end else begin
      res.rom_addr = rom_off & rmask;
    end
    // Peripheral windows
    res.enables[EN_MSU]     = feat[FEAT_MSU1] && low_bank
                              && (off >= 16'h2000) && (off <= 16'h2007);
    res.enables[EN_213F]    = feat[FEAT_213F] && (req.pa == 8'h3F);
    res.enables[EN_SNESCMD] = low_bank && (off >= 16'h2A00) && (off <= 16'h2BFF);
    res.enables[EN_NMICMD]  = (req.addr == NMICMD_ADDR);
    res.enables[EN_RETVEC]  = (req.addr == RETVEC_ADDR);
    res.enables[EN_BRANCH1] = (req.addr == BRANCH1_ADDR);
    res.enables[EN_BRANCH2] = (req.addr == BRANCH2_ADDR);
    // GSU registers stop short of 3300
    res.enables[EN_GSU]     = feat[FEAT_GSU] && low_bank
                              && (off >= 16'h3000) && (off <= 16'h32FF);
    return res;
  endfunction

endpackage

//--- sim/tb_cart_map.sv
`timescale 1ns/1ps

module tb_cart_map;

  import snes_bus_pkg::*;
  import cart_cfg_pkg::*;
  import tb_cart_model::*;

  localparam int BUSY_LIMIT  = 200;
  localparam int DRAIN_LIMIT = 4000;
  localparam int STROBES     = 80;

  logic        CLK;
  logic        rst_n;
  logic [7:0]  featurebits;
  cart_mask_t  saveram_mask;
  cart_mask_t  rom_mask;
  logic        cyc_start;
  snes_addr_t  bus_addr;
  logic [7:0]  bus_pa;
  logic        bus_romsel;
  // Driven only by the responder
  logic        mem_ack = 1'b0;
  logic        busy;
  logic [7:0]  overrun_count;
  logic        mem_req;
  logic [23:0] mem_rom_addr;
  logic        mem_rom_hit;
  logic        mem_is_rom;
  logic        mem_is_saveram;
  logic        mem_is_writable;
  logic [7:0]  mem_enables;

  // Expected results, oldest first
  map_res_t    exp_q[$];
  logic [31:0] rng;
  int          mismatches;
  int          failures;
  int          overruns_exp;
  int          results_seen;
  // Memory-side responder
  logic        hold_ack;
  logic        req_seen;
  logic        ack_next;
  int          ack_delay;

  cart_map_top #(
    .REQ_DEPTH (4),
    .RES_DEPTH (4)
  ) i_dut (
    .CLK             (CLK),
    .rst_n           (rst_n),
    .featurebits     (featurebits),
    .saveram_mask    (saveram_mask),
    .rom_mask        (rom_mask),
    .cyc_start       (cyc_start),
    .bus_addr        (bus_addr),
    .bus_pa          (bus_pa),
    .bus_romsel      (bus_romsel),
    .mem_ack         (mem_ack),
    .busy            (busy),
    .overrun_count   (overrun_count),
    .mem_req         (mem_req),
    .mem_rom_addr    (mem_rom_addr),
    .mem_rom_hit     (mem_rom_hit),
    .mem_is_rom      (mem_is_rom),
    .mem_is_saveram  (mem_is_saveram),
    .mem_is_writable (mem_is_writable),
    .mem_enables     (mem_enables)
  );

  // 40 ns clock
  always #20 CLK = ~CLK;

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  task automatic compare_value(input string name, input logic [23:0] got,
                               input logic [23:0] want);
    assert (got === want) else begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, want);
      mismatches++;
    end
  endtask

  // Head of the memory port against the oldest expected result
  task automatic check_result();
    map_res_t want;
    assert (exp_q.size() > 0) else begin
      $display("memory port offered a result at %0t ns with none outstanding", $time);
      failures++;
    end
    if (exp_q.size() > 0) begin
      want = exp_q.pop_front();
      compare_value("mem_rom_addr", mem_rom_addr, want.rom_addr);
      compare_value("mem_rom_hit", mem_rom_hit, want.rom_hit);
      compare_value("mem_is_rom", mem_is_rom, want.is_rom);
      compare_value("mem_is_saveram", mem_is_saveram, want.is_saveram);
      compare_value("mem_is_writable", mem_is_writable, want.is_writable);
      compare_value("mem_enables", mem_enables, want.enables);
      results_seen++;
    end
  endtask

  //////////////////////////////
  // Memory-side responder
  //////////////////////////////

  // Samples 1 ns after the edge, drives ack 2 ns after it
  always @(posedge CLK) begin
    #1;
    ack_next = mem_ack;
    if (!rst_n) begin
      ack_next  = 1'b0;
      req_seen  = 1'b0;
      ack_delay = 0;
    end else begin
      // Rising req, new result at the head
      if (mem_req && !req_seen) begin
        check_result();
        ack_delay = int'(next_rand() % 32'd8);
      end
      if (mem_ack && !mem_req) begin
        ack_next = 1'b0;
      end else if (mem_req && !mem_ack && !hold_ack) begin
        if (ack_delay == 0) begin
          ack_next = 1'b1;
        end else begin
          ack_delay--;
        end
      end
      req_seen = mem_req;
    end
    #1;
    mem_ack = ack_next;
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Weighted toward the interesting windows
  function automatic snes_addr_t pick_addr();
    logic [31:0] r;
    logic [31:0] s;
    snes_addr_t  a;
    r = next_rand();
    s = next_rand();
    case (r % 32'd10)
      0, 1: a = {s[23], 1'b1, s[21:0]};
      2: a = {s[23], 1'b0, s[21:16], 1'b1, s[14:0]};
      3: a = {s[23], 2'b11, s[20:0]};
      4: a = {s[23], 1'b0, s[21:16], 3'b011, s[12:0]};
      // 2000-200F, edge of the MSU window
      5: a = {s[23], 1'b0, s[21:16], 12'h200, s[3:0]};
      6: a = {s[23], 1'b0, s[21:16], 6'b001100, s[9:0]};
      7: a = {s[23], 1'b0, s[21:16], 7'b0010101, s[8:0]};
      8: begin
        case (s[1:0])
          2'd0:    a = NMICMD_ADDR;
          2'd1:    a = RETVEC_ADDR;
          2'd2:    a = BRANCH1_ADDR;
          default: a = BRANCH2_ADDR;
        endcase
      end
      default: a = s[23:0];
    endcase
    return a;
  endfunction

  // One strobe, accepted only if capture is idle at the next edge
  task automatic send_strobe(input snes_addr_t addr, input logic [7:0] pa,
                             input logic romsel);
    snes_req_t req;
    req        = '{addr, pa, romsel};
    cyc_start  = 1'b1;
    bus_addr   = addr;
    bus_pa     = pa;
    bus_romsel = romsel;
    if (busy) begin
      overruns_exp++;
    end else begin
      exp_q.push_back(model_map(featurebits, saveram_mask, rom_mask, req));
    end
    @(posedge CLK);
    #2;
    cyc_start = 1'b0;
  endtask

  task automatic send_random();
    logic [31:0] r;
    snes_addr_t  a;
    a = pick_addr();
    r = next_rand();
    // PA 3F about one time in four
    send_strobe(a, (r[9:8] == 2'b00) ? 8'h3F : r[23:16], r[4]);
  endtask

  task automatic wait_not_busy();
    int n;
    n = 0;
    while (busy && (n < BUSY_LIMIT)) begin
      @(posedge CLK);
      #2;
      n++;
    end
    assert (!busy) else begin
      $display("capture still busy after %0d cycles at %0t ns", BUSY_LIMIT, $time);
      failures++;
    end
  endtask

  // Until every accepted request has come out
  task automatic drain();
    int n;
    n = 0;
    while (((exp_q.size() != 0) || mem_req || busy) && (n < DRAIN_LIMIT)) begin
      @(posedge CLK);
      #2;
      n++;
    end
    assert ((exp_q.size() == 0) && !mem_req && !busy) else begin
      $display("pipeline did not drain within %0d cycles, %0d results missing",
               DRAIN_LIMIT, exp_q.size());
      failures++;
    end
  endtask

  task automatic set_config(input int p);
    logic [31:0] r;
    case (p)
      0: begin
        featurebits  = 8'h38;
        saveram_mask = 24'h001FFF;
        rom_mask     = 24'h1FFFFF;
      end
      // Save RAM off, no features
      1: begin
        featurebits  = 8'h00;
        saveram_mask = 24'h00FFFE;
        rom_mask     = 24'h0FFFFF;
      end
      2: begin
        featurebits  = 8'h28;
        saveram_mask = 24'h01FFFF;
        rom_mask     = 24'h3FFFFF;
      end
      default: begin
        r            = next_rand();
        featurebits  = r[7:0];
        r            = next_rand();
        saveram_mask = r[23:0] | 24'd1;
        r            = next_rand();
        rom_mask     = r[23:0];
      end
    endcase
  endtask

  initial begin
    int gap;
    CLK          = 1'b0;
    rst_n        = 1'b0;
    featurebits  = 8'h00;
    saveram_mask = '0;
    rom_mask     = '0;
    cyc_start    = 1'b0;
    bus_addr     = '0;
    bus_pa       = 8'h00;
    bus_romsel   = 1'b1;
    hold_ack     = 1'b0;
    rng          = 32'd99224;
    mismatches   = 0;
    failures     = 0;
    overruns_exp = 0;
    results_seen = 0;
    repeat (4) @(posedge CLK);
    #2;
    rst_n = 1'b1;

    // State right out of reset
    compare_value("busy", busy, 24'd0);
    compare_value("mem_req", mem_req, 24'd0);
    compare_value("overrun_count", overrun_count, 24'd0);

    // Paced traffic, one config per phase
    for (int p = 0; p < 5; p++) begin
      set_config(p);
      for (int i = 0; i < STROBES; i++) begin
        wait_not_busy();
        send_random();
        gap = int'(next_rand() % 32'd4);
        repeat (gap) begin
          @(posedge CLK);
          #2;
        end
      end
      drain();
    end

    //////////////////////////////
    // Back-pressure
    //////////////////////////////

    set_config(0);
    hold_ack = 1'b1;
    // A strobe every cycle, busy or not
    for (int i = 0; i < 48; i++) begin
      send_random();
    end
    hold_ack = 1'b0;
    drain();
    compare_value("overrun_count", overrun_count, 24'(overruns_exp));

    assert (exp_q.size() == 0) else begin
      $display("%0d accepted requests never reached the memory port", exp_q.size());
      failures++;
    end
    $display("errors: %0d mismatches, %0d other failures (%0d results checked)",
             mismatches, failures, results_seen);
    if ((mismatches == 0) && (failures == 0)) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
source/snes_bus_pkg.sv
source/cart_cfg_pkg.sv
source/snes_req_capture.sv
source/req_fifo.sv
source/address_decode.sv
source/map_stage.sv
source/cart_map_top.sv
sim/tb_cart_model.sv
sim/tb_cart_map.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cart_map \
  -f build.f \
  -o sim_tb_cart_map

out=$(./obj_dir/sim_tb_cart_map)
echo "$out"

if echo "$out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1
